/* flist.f */
rmt_pkg.sv
sync_fifo.sv
pkt_filter.sv
hdr_parser.sv
match_stage.sv
hdr_deparser.sv
output_arbiter.sv
rmt_pipeline_top.sv
tb_checker.sv
tb_rmt_top.sv

/* Bender.yml */
package:
  name: rmt_pipeline

sources:
  - rmt_pkg.sv
  - sync_fifo.sv
  - pkt_filter.sv
  - hdr_parser.sv
  - match_stage.sv
  - hdr_deparser.sv
  - output_arbiter.sv
  - rmt_pipeline_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_rmt_top.sv

/* tb_rmt_top.sv */
`timescale 1ns/1ns

module tb_rmt_top;
	import rmt_pkg::*;

	localparam int num_entries  = 10;
	localparam int sample_delay = 5;
	localparam int wait_limit   = 2000;
	localparam int drain_limit  = 5000;

	logic              clk;
	logic              aresetn;
	logic [31:0]       vlan_drop_flags;
	logic [data_w-1:0] s_axis_tdata;
	logic [user_w-1:0] s_axis_tuser;
	logic              s_axis_tlast;
	logic              s_axis_tvalid;
	logic              s_axis_tready;
	logic [data_w-1:0] m_axis_tdata;
	logic [user_w-1:0] m_axis_tuser;
	logic              m_axis_tlast;
	logic              m_axis_tvalid;
	logic              m_axis_tready;

	int          seed;
	logic [31:0] rnd_word;
	logic        random_ready;
	logic        timeout_hit;
	int          exp_pkts;
	int          got_pkts;
	int          errors;

	// packet table, flags 0x12 drop low vlan bits 1 and 4
	logic [vlan_w-1:0]  tbl_vlan  [num_entries] = '{12'h005, 12'h001, 12'h010, 12'h102,
		12'h004, 12'h003, 12'h00a, 12'h0ff, 12'h024, 12'h008};
	logic [field_w-1:0] tbl_a     [num_entries] = '{16'h0001, 16'h0101, 16'h1234, 16'h00ff,
		16'h0202, 16'h8000, 16'h0003, 16'habcd, 16'h0303, 16'h0042};
	logic [field_w-1:0] tbl_b     [num_entries] = '{16'h0002, 16'h0102, 16'hffff, 16'h0100,
		16'h0203, 16'h8000, 16'h0004, 16'h1111, 16'h0304, 16'h0000};
	logic [field_w-1:0] tbl_c     [num_entries] = '{16'h0003, 16'h0103, 16'hfffe, 16'h0010,
		16'h0204, 16'h0001, 16'h0005, 16'h2222, 16'h0305, 16'hffff};
	int                 tbl_beats [num_entries] = '{1, 2, 3, 4, 1, 2, 1, 5, 3, 2};
	logic [user_w-1:0]  tbl_user  [num_entries] = '{16'h1111, 16'h2220, 16'h3330, 16'h4440,
		16'h5550, 16'h6660, 16'h7770, 16'h8880, 16'h9990, 16'haaa0};

	rmt_pipeline_top #(
		.NUM_QUEUES (num_queues_d),
		.NUM_STAGES (num_stages_d)
	) DUT (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tuser    (s_axis_tuser),
		.s_axis_tlast    (s_axis_tlast),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.m_axis_tdata    (m_axis_tdata),
		.m_axis_tuser    (m_axis_tuser),
		.m_axis_tlast    (m_axis_tlast),
		.m_axis_tvalid   (m_axis_tvalid),
		.m_axis_tready   (m_axis_tready)
	);

	tb_checker #(
		.NUM_QUEUES (num_queues_d),
		.NUM_STAGES (num_stages_d)
	) u_checker (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tuser    (s_axis_tuser),
		.s_axis_tlast    (s_axis_tlast),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.m_axis_tdata    (m_axis_tdata),
		.m_axis_tuser    (m_axis_tuser),
		.m_axis_tlast    (m_axis_tlast),
		.m_axis_tvalid   (m_axis_tvalid),
		.m_axis_tready   (m_axis_tready),
		.exp_pkts        (exp_pkts),
		.got_pkts        (got_pkts),
		.errors          (errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// output backpressure, random in the second pass
	always @(negedge clk) begin
		rnd_word = $random(seed);
		m_axis_tready = random_ready ? rnd_word[0] : 1'b1;
	end

	task automatic send_packet(input int pass, input int idx);
		logic [data_w-1:0] d;
		int                waited;
		logic              took;
		for (int b = 0; b < tbl_beats[idx] && !timeout_hit; b++) begin
			if (b == 0)
				d = {tbl_vlan[idx], 4'(idx) ^ 4'ha, tbl_a[idx], tbl_b[idx], tbl_c[idx]};
			else
				d = {8'(pass), 8'(idx), 16'(b), 32'hd00d_0000 + 32'(b)};
			s_axis_tdata  = d;
			s_axis_tuser  = tbl_user[idx] + 16'(b);
			s_axis_tlast  = (b == tbl_beats[idx] - 1);
			s_axis_tvalid = 1'b1;
			took   = 1'b0;
			waited = 0;
			while (!took && !timeout_hit) begin
				#(sample_delay);
				took = s_axis_tready;
				@(negedge clk);
				waited++;
				if (!took && waited >= wait_limit) begin
					$display("Timeout: beat %0d of packet %0d was never accepted", b, idx);
					timeout_hit = 1'b1;
				end
			end
		end
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (got_pkts < exp_pkts && !timeout_hit) begin
			@(negedge clk);
			waited++;
			if (waited >= drain_limit) begin
				$display("Timeout: only %0d of %0d packets left the pipeline",
					got_pkts, exp_pkts);
				timeout_hit = 1'b1;
			end
		end
		// dropped or duplicated packets would still show up here
		repeat (40) @(negedge clk);
	endtask

	initial begin
		seed            = 88;
		aresetn         = 1'b0;
		vlan_drop_flags = 32'h0000_0012;
		s_axis_tdata    = '0;
		s_axis_tuser    = '0;
		s_axis_tlast    = 1'b0;
		s_axis_tvalid   = 1'b0;
		m_axis_tready   = 1'b0;
		random_ready    = 1'b0;
		timeout_hit     = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		for (int pass = 0; pass < 2; pass++) begin
			random_ready = (pass == 1);
			for (int i = 0; i < num_entries; i++) begin
				if (!timeout_hit)
					send_packet(pass, i);
			end
		end
		if (!timeout_hit)
			wait_drain();
		$display("summary: %0d packets expected, %0d received, %0d errors",
			exp_pkts, got_pkts, errors);
		if (!timeout_hit && errors == 0 && got_pkts == exp_pkts) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns

module tb_checker #(
	parameter int NUM_QUEUES = rmt_pkg::num_queues_d,
	parameter int NUM_STAGES = rmt_pkg::num_stages_d
) (
	input  logic                       clk,
	input  logic                       aresetn,
	input  logic [31:0]                vlan_drop_flags,
	input  logic [rmt_pkg::data_w-1:0] s_axis_tdata,
	input  logic [rmt_pkg::user_w-1:0] s_axis_tuser,
	input  logic                       s_axis_tlast,
	input  logic                       s_axis_tvalid,
	input  logic                       s_axis_tready,
	input  logic [rmt_pkg::data_w-1:0] m_axis_tdata,
	input  logic [rmt_pkg::user_w-1:0] m_axis_tuser,
	input  logic                       m_axis_tlast,
	input  logic                       m_axis_tvalid,
	input  logic                       m_axis_tready,
	output int                         exp_pkts,
	output int                         got_pkts,
	output int                         errors
);
	import rmt_pkg::*;

	// quarter period after the falling edge, all signals settled
	localparam int sample_delay = 5;

	// expected beats, one list per output queue
	beat_t exp_q [NUM_QUEUES][$];

	logic in_first;
	logic in_drop;
	int   in_q;
	logic out_first;
	int   out_q;
	int   out_beats;
	logic pkt_bad;

	initial begin
		exp_pkts  = 0;
		got_pkts  = 0;
		errors    = 0;
		in_first  = 1'b1;
		in_drop   = 1'b0;
		in_q      = 0;
		out_first = 1'b1;
		out_q     = 0;
		out_beats = 0;
		pkt_bad   = 1'b0;
	end

	task automatic record_input_beat();
		beat_t              b;
		logic [vlan_w-1:0]  vlan;
		logic [field_w-1:0] fa;
		logic [field_w-1:0] fb;
		logic [field_w-1:0] fc;
		b.data = s_axis_tdata;
		b.user = s_axis_tuser;
		b.last = s_axis_tlast;
		if (in_first) begin
			vlan    = s_axis_tdata[vlan_lsb +: vlan_w];
			in_drop = vlan_drop_flags[vlan[4:0]];
			in_q    = int'(vlan) % NUM_QUEUES;
			fa      = s_axis_tdata[fa_lsb +: field_w];
			fb      = s_axis_tdata[fb_lsb +: field_w];
			fc      = s_axis_tdata[fc_lsb +: field_w];
			// net effect of the whole stage chain
			b.data[fb_lsb +: field_w] = field_w'(int'(fb) + NUM_STAGES * int'(fa));
			b.data[fc_lsb +: field_w] = field_w'(int'(fc) + NUM_STAGES * (NUM_STAGES + 1) / 2);
			if (!in_drop)
				exp_pkts++;
		end
		if (!in_drop)
			exp_q[in_q].push_back(b);
		in_first = s_axis_tlast;
	endtask

	task automatic check_output_beat();
		beat_t e;
		if (out_first) begin
			out_q     = int'(m_axis_tdata[vlan_lsb +: vlan_w]) % NUM_QUEUES;
			out_beats = 0;
			pkt_bad   = 1'b0;
		end
		out_beats++;
		if (exp_q[out_q].size() == 0) begin
			$display("Output beat at %0t in queue %0d belongs to no expected packet",
				$time, out_q);
			errors++;
			pkt_bad = 1'b1;
		end else begin
			e = exp_q[out_q].pop_front();
			if (m_axis_tdata !== e.data) begin
				$display("Error at %0t: m_axis_tdata expected %h, got %h",
					$time, e.data, m_axis_tdata);
				errors++;
				pkt_bad = 1'b1;
			end
			if (m_axis_tuser !== e.user) begin
				$display("Error at %0t: m_axis_tuser expected %h, got %h",
					$time, e.user, m_axis_tuser);
				errors++;
				pkt_bad = 1'b1;
			end
			if (m_axis_tlast !== e.last) begin
				$display("Error at %0t: m_axis_tlast expected %b, got %b",
					$time, e.last, m_axis_tlast);
				errors++;
				pkt_bad = 1'b1;
			end
		end
		if (m_axis_tlast) begin
			got_pkts++;
			$display("packet %0d queue %0d beats %0d: %s", got_pkts, out_q, out_beats,
				pkt_bad ? "FAIL" : "ok");
		end
		out_first = m_axis_tlast;
	endtask

	// transfers happen at the next rising edge
	always @(negedge clk) begin
		#(sample_delay);
		if (aresetn) begin
			if (s_axis_tvalid && s_axis_tready)
				record_input_beat();
			if (m_axis_tvalid && m_axis_tready)
				check_output_beat();
		end
	end

endmodule

/* rmt_pipeline_top.sv */
`timescale 1ns/1ns

module rmt_pipeline_top #(
	parameter int NUM_QUEUES = rmt_pkg::num_queues_d,
	parameter int NUM_STAGES = rmt_pkg::num_stages_d
) (
	input  logic                       clk,
	input  logic                       aresetn,
	input  logic [31:0]                vlan_drop_flags,
	input  logic [rmt_pkg::data_w-1:0] s_axis_tdata,
	input  logic [rmt_pkg::user_w-1:0] s_axis_tuser,
	input  logic                       s_axis_tlast,
	input  logic                       s_axis_tvalid,
	output logic                       s_axis_tready,
	output logic [rmt_pkg::data_w-1:0] m_axis_tdata,
	output logic [rmt_pkg::user_w-1:0] m_axis_tuser,
	output logic                       m_axis_tlast,
	output logic                       m_axis_tvalid,
	input  logic                       m_axis_tready
);
	import rmt_pkg::*;

	beat_t filt_beat;
	logic  filt_valid;
	logic  filt_ready;
	beat_t pkt_beat;

	logic [NUM_QUEUES-1:0] pkt_wr_en;
	logic [NUM_QUEUES-1:0] pkt_rd_en;
	logic [NUM_QUEUES-1:0] pkt_nearly_full;
	logic [NUM_QUEUES-1:0] pkt_empty;
	beat_t                 pkt_head [NUM_QUEUES];

	logic [NUM_QUEUES-1:0] phv_wr_en;
	logic [NUM_QUEUES-1:0] phv_rd_en;
	logic [NUM_QUEUES-1:0] phv_nearly_full;
	logic [NUM_QUEUES-1:0] phv_empty;
	phv_t                  phv_head [NUM_QUEUES];

	// stage chain, index 0 is the parser output
	phv_t stg_phv   [NUM_STAGES+1];
	logic stg_valid [NUM_STAGES+1];

	beat_t                 dep_beat [NUM_QUEUES];
	logic [NUM_QUEUES-1:0] dep_valid;
	logic [NUM_QUEUES-1:0] dep_ready;

	pkt_filter u_filter (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tuser    (s_axis_tuser),
		.s_axis_tlast    (s_axis_tlast),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.out_beat        (filt_beat),
		.out_valid       (filt_valid),
		.out_ready       (filt_ready)
	);

	hdr_parser #(.NUM_QUEUES(NUM_QUEUES)) u_parser (
		.clk             (clk),
		.aresetn         (aresetn),
		.in_beat         (filt_beat),
		.in_valid        (filt_valid),
		.in_ready        (filt_ready),
		.pkt_nearly_full (pkt_nearly_full),
		.phv_nearly_full (phv_nearly_full),
		.pkt_wr_en       (pkt_wr_en),
		.pkt_beat        (pkt_beat),
		.phv             (stg_phv[0]),
		.phv_valid       (stg_valid[0])
	);

	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		match_stage #(.STAGE_ID(s)) u_stage (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in        (stg_phv[s]),
			.phv_in_valid  (stg_valid[s]),
			.phv_out       (stg_phv[s+1]),
			.phv_out_valid (stg_valid[s+1])
		);
	end

	for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
		// last stage vector goes to the header FIFO named by its queue index
		assign phv_wr_en[q] = stg_valid[NUM_STAGES] &&
			(stg_phv[NUM_STAGES].queue == queue_t'(q));

		sync_fifo #(
			.T          (beat_t),
			.DEPTH_BITS (pkt_fifo_depth_bits_d),
			.MARGIN     (2)
		) u_pkt_fifo (
			.clk         (clk),
			.aresetn     (aresetn),
			.din         (pkt_beat),
			.wr_en       (pkt_wr_en[q]),
			.rd_en       (pkt_rd_en[q]),
			.dout        (pkt_head[q]),
			.nearly_full (pkt_nearly_full[q]),
			.empty       (pkt_empty[q])
		);

		// margin covers the vectors still in the stage chain
		sync_fifo #(
			.T          (phv_t),
			.DEPTH_BITS (phv_fifo_depth_bits_d),
			.MARGIN     (NUM_STAGES + 2)
		) u_phv_fifo (
			.clk         (clk),
			.aresetn     (aresetn),
			.din         (stg_phv[NUM_STAGES]),
			.wr_en       (phv_wr_en[q]),
			.rd_en       (phv_rd_en[q]),
			.dout        (phv_head[q]),
			.nearly_full (phv_nearly_full[q]),
			.empty       (phv_empty[q])
		);

		hdr_deparser u_deparser (
			.clk       (clk),
			.aresetn   (aresetn),
			.pkt_head  (pkt_head[q]),
			.pkt_empty (pkt_empty[q]),
			.pkt_rd_en (pkt_rd_en[q]),
			.phv_head  (phv_head[q]),
			.phv_empty (phv_empty[q]),
			.phv_rd_en (phv_rd_en[q]),
			.out_beat  (dep_beat[q]),
			.out_valid (dep_valid[q]),
			.out_ready (dep_ready[q])
		);
	end

	output_arbiter #(.NUM_QUEUES(NUM_QUEUES)) u_arbiter (
		.clk           (clk),
		.aresetn       (aresetn),
		.in_beat       (dep_beat),
		.in_valid      (dep_valid),
		.in_ready      (dep_ready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

endmodule

/* output_arbiter.sv */
`timescale 1ns/1ns

module output_arbiter #(
	parameter int NUM_QUEUES = rmt_pkg::num_queues_d
) (
	input  logic                       clk,
	input  logic                       aresetn,
	input  rmt_pkg::beat_t             in_beat [NUM_QUEUES],
	input  logic [NUM_QUEUES-1:0]      in_valid,
	output logic [NUM_QUEUES-1:0]      in_ready,
	output logic [rmt_pkg::data_w-1:0] m_axis_tdata,
	output logic [rmt_pkg::user_w-1:0] m_axis_tuser,
	output logic                       m_axis_tlast,
	output logic                       m_axis_tvalid,
	input  logic                       m_axis_tready
);
	import rmt_pkg::*;

	localparam int gw = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

	logic [gw-1:0] grant;
	logic [gw-1:0] pick;
	logic [gw-1:0] sel;
	logic          busy;

	// search starts right after the last grant and wraps back to it
	always_comb begin
		int idx;
		logic found;
		pick  = grant;
		found = 1'b0;
		for (int k = 1; k <= NUM_QUEUES; k++) begin
			idx = (int'(grant) + k) % NUM_QUEUES;
			if (!found && in_valid[idx]) begin
				pick  = gw'(idx);
				found = 1'b1;
			end
		end
	end

	assign sel = busy ? grant : pick;

	assign m_axis_tvalid = in_valid[sel];
	assign m_axis_tdata  = in_beat[sel].data;
	assign m_axis_tuser  = in_beat[sel].user;
	assign m_axis_tlast  = in_beat[sel].last;

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++)
			in_ready[i] = m_axis_tready && (sel == gw'(i));
	end

	// lock on the first presented beat, release after the tlast transfer
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			grant <= '0;
			busy  <= 1'b0;
		end else if (m_axis_tvalid) begin
			grant <= sel;
			busy  <= !(m_axis_tready && m_axis_tlast);
		end
	end

endmodule

/* hdr_deparser.sv */
`timescale 1ns/1ns

module hdr_deparser (
	input  logic           clk,
	input  logic           aresetn,
	input  rmt_pkg::beat_t pkt_head,
	input  logic           pkt_empty,
	output logic           pkt_rd_en,
	input  rmt_pkg::phv_t  phv_head,
	input  logic           phv_empty,
	output logic           phv_rd_en,
	output rmt_pkg::beat_t out_beat,
	output logic           out_valid,
	input  logic           out_ready
);
	import rmt_pkg::*;

	logic first;
	logic xfer;

	// a packet only leaves once its header vector is there
	assign out_valid = !pkt_empty && !phv_empty;
	assign xfer      = out_valid && out_ready;

	always_comb begin
		out_beat = pkt_head;
		// vlan id and reserved bits pass through
		if (first) begin
			out_beat.data[fa_lsb +: field_w] = phv_head.a;
			out_beat.data[fb_lsb +: field_w] = phv_head.b;
			out_beat.data[fc_lsb +: field_w] = phv_head.c;
		end
	end

	assign pkt_rd_en = xfer;
	// one vector per packet, released with the last beat
	assign phv_rd_en = xfer && pkt_head.last;

	always_ff @(posedge clk) begin
		if (!aresetn)
			first <= 1'b1;
		else if (xfer)
			first <= pkt_head.last;
	end

endmodule

/* match_stage.sv */
`timescale 1ns/1ns

module match_stage #(
	parameter int STAGE_ID = 0
) (
	input  logic          clk,
	input  logic          aresetn,
	input  rmt_pkg::phv_t phv_in,
	input  logic          phv_in_valid,
	output rmt_pkg::phv_t phv_out,
	output logic          phv_out_valid
);
	import rmt_pkg::*;

	logic [field_w-1:0] b_next;
	logic [field_w-1:0] c_next;

	// fixed action of this stage, both sums wrap at 16 bits
	assign b_next = phv_in.b + phv_in.a;
	assign c_next = phv_in.c + field_w'(STAGE_ID + 1);

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	// one vector per cycle, no stall
	always_ff @(posedge clk) begin
		if (phv_in_valid) begin
			phv_out.vlan  <= phv_in.vlan;
			phv_out.queue <= phv_in.queue;
			phv_out.a     <= phv_in.a;
			phv_out.b     <= b_next;
			phv_out.c     <= c_next;
		end
	end

endmodule

/* hdr_parser.sv */
`timescale 1ns/1ns

module hdr_parser #(
	parameter int NUM_QUEUES = rmt_pkg::num_queues_d
) (
	input  logic                  clk,
	input  logic                  aresetn,
	input  rmt_pkg::beat_t        in_beat,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [NUM_QUEUES-1:0] pkt_nearly_full,
	input  logic [NUM_QUEUES-1:0] phv_nearly_full,
	output logic [NUM_QUEUES-1:0] pkt_wr_en,
	output rmt_pkg::beat_t        pkt_beat,
	output rmt_pkg::phv_t         phv,
	output logic                  phv_valid
);
	import rmt_pkg::*;

	logic   first;
	logic   accept;
	queue_t new_q;
	queue_t q_reg;
	queue_t cur_q;

	// any full queue stalls the whole input
	assign in_ready = !(|pkt_nearly_full) && !(|phv_nearly_full);
	assign accept   = in_valid && in_ready;

	assign new_q = queue_t'(in_beat.data[vlan_lsb +: vlan_w] % NUM_QUEUES);
	// queue chosen at the first beat holds through tlast
	assign cur_q = first ? new_q : q_reg;

	assign pkt_beat = in_beat;

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++)
			pkt_wr_en[i] = accept && (cur_q == queue_t'(i));
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first     <= 1'b1;
			q_reg     <= '0;
			phv_valid <= 1'b0;
		end else begin
			phv_valid <= accept && first;
			if (accept) begin
				first <= in_beat.last;
				q_reg <= cur_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && first) begin
			phv.vlan  <= in_beat.data[vlan_lsb +: vlan_w];
			phv.queue <= new_q;
			phv.a     <= in_beat.data[fa_lsb +: field_w];
			phv.b     <= in_beat.data[fb_lsb +: field_w];
			phv.c     <= in_beat.data[fc_lsb +: field_w];
		end
	end

endmodule

/* pkt_filter.sv */
`timescale 1ns/1ns

module pkt_filter (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic [31:0]               vlan_drop_flags,
	input  logic [rmt_pkg::data_w-1:0] s_axis_tdata,
	input  logic [rmt_pkg::user_w-1:0] s_axis_tuser,
	input  logic                      s_axis_tlast,
	input  logic                      s_axis_tvalid,
	output logic                      s_axis_tready,
	output rmt_pkg::beat_t            out_beat,
	output logic                      out_valid,
	input  logic                      out_ready
);
	import rmt_pkg::*;

	logic started;
	logic first;
	logic dropping;
	logic drop_now;
	logic accept;

	// flag bit picked by the low five bits of the vlan id
	assign drop_now = dropping || (first && vlan_drop_flags[s_axis_tdata[vlan_lsb +: 5]]);

	// dropped beats are swallowed regardless of the downstream state
	assign s_axis_tready = started && (drop_now || !out_valid || out_ready);
	assign accept = s_axis_tvalid && s_axis_tready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			started   <= 1'b0;
			first     <= 1'b1;
			dropping  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			started <= 1'b1;
			if (accept) begin
				first    <= s_axis_tlast;
				dropping <= drop_now && !s_axis_tlast;
			end
			if (out_valid && out_ready)
				out_valid <= 1'b0;
			if (accept && !drop_now)
				out_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !drop_now) begin
			out_beat.data <= s_axis_tdata;
			out_beat.user <= s_axis_tuser;
			out_beat.last <= s_axis_tlast;
		end
	end

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
	parameter type T          = logic [7:0],
	parameter int  DEPTH_BITS = 4,
	parameter int  MARGIN     = 1
) (
	input  logic clk,
	input  logic aresetn,
	input  T     din,
	input  logic wr_en,
	input  logic rd_en,
	output T     dout,
	output logic nearly_full,
	output logic empty
);
	localparam int DEPTH = 2 ** DEPTH_BITS;

	T mem [DEPTH];

	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr_en && (count != DEPTH[DEPTH_BITS:0]);
	assign do_rd = rd_en && !empty;

	// head entry shows while not empty
	assign dout        = mem[rd_ptr];
	assign empty       = (count == '0);
	assign nearly_full = (DEPTH - int'(count)) < MARGIN;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (do_wr ? 1'b1 : 1'b0) - (do_rd ? 1'b1 : 1'b0);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

/* rmt_pkg.sv */
package rmt_pkg;

	// stream and header widths
	localparam int data_w  = 64;
	localparam int user_w  = 16;
	localparam int vlan_w  = 12;
	localparam int field_w = 16;
	localparam int queue_w = 2;

	// first beat layout, bits 51..48 are reserved and never touched
	localparam int vlan_lsb = 52;
	localparam int fa_lsb   = 32;
	localparam int fb_lsb   = 16;
	localparam int fc_lsb   = 0;

	// defaults for the top level
	localparam int num_queues_d          = 4;
	localparam int num_stages_d          = 3;
	localparam int pkt_fifo_depth_bits_d = 4;
	localparam int phv_fifo_depth_bits_d = 3;

	typedef logic [queue_w-1:0] queue_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [user_w-1:0] user;
		logic              last;
	} beat_t;

	typedef struct packed {
		logic [vlan_w-1:0]  vlan;
		queue_t             queue;
		logic [field_w-1:0] a;
		logic [field_w-1:0] b;
		logic [field_w-1:0] c;
	} phv_t;

endpackage
